//--- design/fetch_pkg.sv
package fetch_pkg;

    // Address and data widths
    localparam int ADDR_W = 32;
    localparam int INSTR_W = 32;

    // Output slots toward the instruction buffer
    localparam int FETCH_W = 4;

    // Cache line geometry, 16-byte lines of 4-byte words
    localparam int LINE_WORDS = 4;
    localparam int BUF_WORDS = 2 * LINE_WORDS;
    localparam int WORD_OFF_W = $clog2(LINE_WORDS);
    localparam int LINE_LSB = WORD_OFF_W + 2;

    // Block length holds 1 to 4
    localparam int LEN_W = 3;

    // Beat counter, one word per Wishbone beat
    localparam int BEAT_W = 4;

    // Controller states
    // DRAIN waits on the final beat of the block
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        BUS   = 2'd1,
        DRAIN = 2'd2,
        OUT   = 2'd3
    } fetch_state_t;

endpackage

//--- design/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic flush_i,
    input  logic ftq_valid_i,
    input  logic wb_ack_i,
    input  logic last_beat_i,
    input  logic ib_stall_i,
    output logic ftq_accept_o,
    output logic wb_cyc_o,
    output logic wb_stb_o,
    output logic load_block_o,
    output logic slot_load_o,
    output logic slots_clear_o
);

    fetch_pkg::fetch_state_t state_q;
    fetch_pkg::fetch_state_t state_d;
    logic bus_busy;

    // Bus cycle covers every beat, including the final one
    assign bus_busy = (state_q == fetch_pkg::BUS) || (state_q == fetch_pkg::DRAIN);

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (ftq_valid_i) begin
                    state_d = fetch_pkg::BUS;
                end
            end
            fetch_pkg::BUS: begin
                // Zero-wait final beat goes straight to output
                if (last_beat_i) begin
                    state_d = wb_ack_i ? fetch_pkg::OUT : fetch_pkg::DRAIN;
                end
            end
            fetch_pkg::DRAIN: begin
                if (wb_ack_i) begin
                    state_d = fetch_pkg::OUT;
                end
            end
            fetch_pkg::OUT: begin
                // Slots held while the buffer stalls
                if (!ib_stall_i) begin
                    state_d = fetch_pkg::IDLE;
                end
            end
            default: state_d = fetch_pkg::IDLE;
        endcase
        // Flush overrides everything
        if (flush_i) begin
            state_d = fetch_pkg::IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fetch_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign ftq_accept_o = (state_q == fetch_pkg::IDLE) && ftq_valid_i && !flush_i;
    assign load_block_o = ftq_accept_o;

    // Classic read, stb tracks cyc
    assign wb_cyc_o = bus_busy;
    assign wb_stb_o = bus_busy;

    // Slicer captures on the final ack, bypassing its data
    assign slot_load_o = bus_busy && wb_ack_i && last_beat_i && !flush_i;
    assign slots_clear_o = flush_i;

endmodule

//--- design/fetch_beat_counter.sv
`timescale 1ns/1ps

module fetch_beat_counter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_block_i,
    input  logic                                wb_ack_i,
    input  logic                                flush_i,
    input  logic [fetch_pkg::ADDR_W-1:0]        ftq_start_pc_i,
    input  logic [fetch_pkg::LEN_W-1:0]         ftq_length_i,
    output logic [fetch_pkg::BEAT_W-1:0]        beat_idx_o,
    output logic                                last_beat_o,
    output logic [fetch_pkg::ADDR_W-1:0]        wb_adr_o,
    output logic [fetch_pkg::WORD_OFF_W-1:0]    start_off_o
);

    logic [fetch_pkg::ADDR_W-1:0]     line_q;
    logic [fetch_pkg::BEAT_W-1:0]     beat_q;
    logic [fetch_pkg::BEAT_W-1:0]     last_idx_q;
    logic [fetch_pkg::WORD_OFF_W-1:0] off_q;
    logic [fetch_pkg::LEN_W:0]        end_sum;
    logic                             crosses;

    // Block crosses when offset plus length runs past the line
    assign end_sum = {{(fetch_pkg::LEN_W + 1 - fetch_pkg::WORD_OFF_W){1'b0}},
                      ftq_start_pc_i[fetch_pkg::LINE_LSB-1:2]} + {1'b0, ftq_length_i};
    assign crosses = end_sum > (fetch_pkg::LEN_W + 1)'(fetch_pkg::LINE_WORDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_q     <= '0;
            beat_q     <= '0;
            last_idx_q <= fetch_pkg::BEAT_W'(fetch_pkg::LINE_WORDS - 1);
            off_q      <= '0;
        end else if (load_block_i) begin
            line_q     <= {ftq_start_pc_i[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_LSB],
                           {fetch_pkg::LINE_LSB{1'b0}}};
            beat_q     <= '0;
            last_idx_q <= crosses ? fetch_pkg::BEAT_W'(fetch_pkg::BUF_WORDS - 1)
                                  : fetch_pkg::BEAT_W'(fetch_pkg::LINE_WORDS - 1);
            off_q      <= ftq_start_pc_i[fetch_pkg::LINE_LSB-1:2];
        end else if (flush_i) begin
            beat_q <= '0;
        end else if (wb_ack_i) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    assign beat_idx_o  = beat_q;
    assign last_beat_o = (beat_q == last_idx_q);
    assign start_off_o = off_q;

    // Word address of the current beat
    assign wb_adr_o = line_q + {{(fetch_pkg::ADDR_W - fetch_pkg::BEAT_W - 2){1'b0}}, beat_q, 2'b00};

endmodule

//--- design/fetch_line_buffer.sv
`timescale 1ns/1ps

module fetch_line_buffer (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          wb_ack_i,
    input  logic [fetch_pkg::BEAT_W-1:0]                  beat_idx_i,
    input  logic [fetch_pkg::INSTR_W-1:0]                 wb_dat_i,
    output logic [fetch_pkg::BUF_WORDS-1:0][fetch_pkg::INSTR_W-1:0] words_o
);

    localparam int IDX_W = $clog2(fetch_pkg::BUF_WORDS);

    logic [fetch_pkg::BUF_WORDS-1:0][fetch_pkg::INSTR_W-1:0] words_q;
    logic                                                    in_range;
    logic [IDX_W-1:0]                                        wr_idx;

    // Beats past the two lines are never stored
    assign in_range = beat_idx_i < fetch_pkg::BEAT_W'(fetch_pkg::BUF_WORDS);
    assign wr_idx   = beat_idx_i[IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            words_q <= '0;
        end else if (wb_ack_i && in_range) begin
            words_q[wr_idx] <= wb_dat_i;
        end
    end

    // All words visible to the slicer at once
    assign words_o = words_q;

endmodule

//--- design/fetch_slicer.sv
`timescale 1ns/1ps

module fetch_slicer (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    load_block_i,
    input  logic                                                    slot_load_i,
    input  logic                                                    slots_clear_i,
    input  logic                                                    ib_stall_i,
    input  logic [fetch_pkg::BUF_WORDS-1:0][fetch_pkg::INSTR_W-1:0] words_i,
    input  logic [fetch_pkg::INSTR_W-1:0]                           wb_dat_i,
    input  logic                                                    wb_ack_i,
    input  logic [fetch_pkg::ADDR_W-1:0]                            start_pc_i,
    input  logic [fetch_pkg::LEN_W-1:0]                             length_i,
    input  logic [fetch_pkg::WORD_OFF_W-1:0]                        start_off_i,
    output logic [fetch_pkg::FETCH_W-1:0]                           ib_valid_o,
    output logic [fetch_pkg::FETCH_W-1:0]                           ib_last_o,
    output logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::ADDR_W-1:0]    ib_pc_o,
    output logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::INSTR_W-1:0]   ib_instr_o
);

    localparam int IDX_W = $clog2(fetch_pkg::BUF_WORDS);

    logic [fetch_pkg::ADDR_W-1:0]                          pc_q;
    logic [fetch_pkg::LEN_W-1:0]                           len_q;
    logic [IDX_W-1:0]                                      final_idx;
    logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::INSTR_W-1:0] pick;

    // Block geometry captured when the queue hands it over
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q  <= '0;
            len_q <= '0;
        end else if (load_block_i) begin
            pc_q  <= start_pc_i;
            len_q <= length_i;
        end
    end

    // Index of the beat still on the bus at load time
    assign final_idx = ({1'b0, start_off_i} + len_q > IDX_W'(fetch_pkg::LINE_WORDS))
                       ? IDX_W'(fetch_pkg::BUF_WORDS - 1) : IDX_W'(fetch_pkg::LINE_WORDS - 1);

    always_comb begin
        logic [IDX_W-1:0] idx;
        for (int i = 0; i < fetch_pkg::FETCH_W; i++) begin
            idx = IDX_W'(start_off_i) + IDX_W'(i);
            // Final word has not reached the buffer yet
            pick[i] = (wb_ack_i && idx == final_idx) ? wb_dat_i : words_i[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ib_valid_o <= '0;
            ib_last_o  <= '0;
            ib_pc_o    <= '0;
            ib_instr_o <= '0;
        end else if (slots_clear_i) begin
            ib_valid_o <= '0;
            ib_last_o  <= '0;
            ib_pc_o    <= '0;
            ib_instr_o <= '0;
        end else if (slot_load_i) begin
            for (int i = 0; i < fetch_pkg::FETCH_W; i++) begin
                if (fetch_pkg::LEN_W'(i) < len_q) begin
                    ib_valid_o[i] <= 1'b1;
                    ib_last_o[i]  <= (fetch_pkg::LEN_W'(i) == len_q - 1'b1);
                    ib_pc_o[i]    <= pc_q + fetch_pkg::ADDR_W'(4 * i);
                    ib_instr_o[i] <= pick[i];
                end else begin
                    ib_valid_o[i] <= 1'b0;
                    ib_last_o[i]  <= 1'b0;
                    ib_pc_o[i]    <= '0;
                    ib_instr_o[i] <= '0;
                end
            end
        end else if (!ib_stall_i) begin
            // Slots given this cycle, drop them
            ib_valid_o <= '0;
            ib_last_o  <= '0;
            ib_pc_o    <= '0;
            ib_instr_o <= '0;
        end
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  flush_i,
    input  logic                                                  ftq_valid_i,
    input  logic [fetch_pkg::ADDR_W-1:0]                          ftq_start_pc_i,
    input  logic [fetch_pkg::LEN_W-1:0]                           ftq_length_i,
    output logic                                                  ftq_accept_o,
    output logic                                                  wb_cyc_o,
    output logic                                                  wb_stb_o,
    output logic [fetch_pkg::ADDR_W-1:0]                          wb_adr_o,
    input  logic [fetch_pkg::INSTR_W-1:0]                         wb_dat_i,
    input  logic                                                  wb_ack_i,
    input  logic                                                  ib_stall_i,
    output logic [fetch_pkg::FETCH_W-1:0]                         ib_valid_o,
    output logic [fetch_pkg::FETCH_W-1:0]                         ib_last_o,
    output logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::ADDR_W-1:0]  ib_pc_o,
    output logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::INSTR_W-1:0] ib_instr_o
);

    logic                                                    load_block;
    logic                                                    slot_load;
    logic                                                    slots_clear;
    logic                                                    last_beat;
    logic [fetch_pkg::BEAT_W-1:0]                            beat_idx;
    logic [fetch_pkg::WORD_OFF_W-1:0]                        start_off;
    logic [fetch_pkg::BUF_WORDS-1:0][fetch_pkg::INSTR_W-1:0] words;

    fetch_ctrl fetch_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .ftq_valid_i  (ftq_valid_i),
        .wb_ack_i     (wb_ack_i),
        .last_beat_i  (last_beat),
        .ib_stall_i   (ib_stall_i),
        .ftq_accept_o (ftq_accept_o),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .load_block_o (load_block),
        .slot_load_o  (slot_load),
        .slots_clear_o(slots_clear)
    );

    fetch_beat_counter fetch_beat_counter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_block_i  (load_block),
        .wb_ack_i      (wb_ack_i),
        .flush_i       (flush_i),
        .ftq_start_pc_i(ftq_start_pc_i),
        .ftq_length_i  (ftq_length_i),
        .beat_idx_o    (beat_idx),
        .last_beat_o   (last_beat),
        .wb_adr_o      (wb_adr_o),
        .start_off_o   (start_off)
    );

    fetch_line_buffer fetch_line_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_ack_i  (wb_ack_i),
        .beat_idx_i(beat_idx),
        .wb_dat_i  (wb_dat_i),
        .words_o   (words)
    );

    fetch_slicer fetch_slicer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_block_i (load_block),
        .slot_load_i  (slot_load),
        .slots_clear_i(slots_clear),
        .ib_stall_i   (ib_stall_i),
        .words_i      (words),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .start_pc_i   (ftq_start_pc_i),
        .length_i     (ftq_length_i),
        .start_off_i  (start_off),
        .ib_valid_o   (ib_valid_o),
        .ib_last_o    (ib_last_o),
        .ib_pc_o      (ib_pc_o),
        .ib_instr_o   (ib_instr_o)
    );

endmodule

//--- bench/wb_inst_mem.sv
`timescale 1ns/1ps

module wb_inst_mem (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  wb_adr_i,
    output logic [fetch_pkg::INSTR_W-1:0] wb_dat_o,
    output logic                          wb_ack_o
);

    integer     seed = 86;
    logic [1:0] wait_q;
    logic [1:0] delay_q;
    logic       req;

    assign req = wb_cyc_i && wb_stb_i;

    // Zero wait states means ack in the first cycle of the beat
    assign wb_ack_o = req && (wait_q == delay_q);
    assign wb_dat_o = wb_adr_i ^ 32'h1357_0000;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q  <= '0;
            delay_q <= '0;
        end else if (!req) begin
            // Master dropped cyc, beat aborted
            wait_q <= '0;
        end else if (wb_ack_o) begin
            wait_q  <= '0;
            delay_q <= 2'($random(seed));
        end else begin
            wait_q <= wait_q + 1'b1;
        end
    end

endmodule

//--- bench/fetch_unit_properties.sv
`timescale 1ns/1ps

module fetch_unit_properties (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                flush_i,
    input fetch_pkg::fetch_state_t             state_i,
    input logic                                cyc_i,
    input logic                                stb_i,
    input logic                                ack_i,
    input logic [fetch_pkg::ADDR_W-1:0]        adr_i,
    input logic [fetch_pkg::FETCH_W-1:0]       valid_i,
    input logic [fetch_pkg::FETCH_W-1:0]       last_i
);

    int fail_count = 0;

    // Request stays up, inside the cycle, until the slave answers
    stb_cyc_held: assert property (@(posedge clk) disable iff (!rst_n)
        (stb_i && !ack_i && !flush_i) |=> (stb_i && cyc_i))
    else begin
        $error("wb_stb_o or wb_cyc_o dropped before wb_ack_i");
        fail_count++;
    end

    // Address held until the slave answers
    adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (stb_i && !ack_i && !flush_i) |=> $stable(adr_i))
    else begin
        $error("wb_adr_o changed before wb_ack_i");
        fail_count++;
    end

    // Valid slots packed from slot 0, last flag on the top one
    slots_packed: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
        && (last_i == (valid_i ^ (valid_i >> 1))))
    else begin
        $error("ib_valid_o or ib_last_o pattern broken");
        fail_count++;
    end

    slots_in_out: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i != '0) |-> (state_i == fetch_pkg::OUT))
    else begin
        $error("valid slots outside the OUT state");
        fail_count++;
    end

endmodule

bind fetch_unit fetch_unit_properties fetch_unit_properties_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush_i(flush_i),
    .state_i(fetch_ctrl_i.state_q),
    .cyc_i  (wb_cyc_o),
    .stb_i  (wb_stb_o),
    .ack_i  (wb_ack_i),
    .adr_i  (wb_adr_o),
    .valid_i(ib_valid_o),
    .last_i (ib_last_o)
);

//--- bench/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

    localparam int MAX_TESTS = 32;
    localparam int FIELDS = 9;
    localparam int TIMEOUT = 200;
    localparam int KIND_B2B = 6;

    logic                                                  clk;
    logic                                                  rst_n;
    logic                                                  flush;
    logic                                                  ftq_valid;
    logic [fetch_pkg::ADDR_W-1:0]                          ftq_start_pc;
    logic [fetch_pkg::LEN_W-1:0]                           ftq_length;
    logic                                                  ftq_accept;
    logic                                                  wb_cyc;
    logic                                                  wb_stb;
    logic                                                  wb_ack;
    logic [fetch_pkg::ADDR_W-1:0]                          wb_adr;
    logic [fetch_pkg::INSTR_W-1:0]                         wb_dat;
    logic                                                  ib_stall;
    logic [fetch_pkg::FETCH_W-1:0]                         ib_valid;
    logic [fetch_pkg::FETCH_W-1:0]                         ib_last;
    logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::ADDR_W-1:0]  ib_pc;
    logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::INSTR_W-1:0] ib_instr;

    logic [31:0] golden [0:MAX_TESTS*FIELDS-1];
    int          err_count;
    int          check_count;
    int          test_count;
    bit          timed_out;

    fetch_unit fetch_unit_i (
        .clk(clk), .rst_n(rst_n), .flush_i(flush),
        .ftq_valid_i(ftq_valid), .ftq_start_pc_i(ftq_start_pc), .ftq_length_i(ftq_length),
        .ftq_accept_o(ftq_accept),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_adr_o(wb_adr),
        .wb_dat_i(wb_dat), .wb_ack_i(wb_ack),
        .ib_stall_i(ib_stall),
        .ib_valid_o(ib_valid), .ib_last_o(ib_last), .ib_pc_o(ib_pc), .ib_instr_o(ib_instr)
    );

    wb_inst_mem wb_inst_mem_i (
        .clk(clk), .rst_n(rst_n), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_adr_i(wb_adr), .wb_dat_o(wb_dat), .wb_ack_o(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check_flag(input string name, input logic act, input logic exp);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, act, exp);
        end
    endtask

    task automatic check_pc(input string name, input logic [fetch_pkg::ADDR_W-1:0] act,
                            input logic [fetch_pkg::ADDR_W-1:0] exp);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_instr(input string name, input logic [fetch_pkg::INSTR_W-1:0] act,
                               input logic [fetch_pkg::INSTR_W-1:0] exp);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_slots(input logic [31:0] pc, input int len, input int base);
        bit on;
        for (int i = 0; i < fetch_pkg::FETCH_W; i++) begin
            on = i < len;
            check_flag($sformatf("ib_valid_o[%0d]", i), ib_valid[i], on);
            check_flag($sformatf("ib_last_o[%0d]", i), ib_last[i], i == len - 1);
            check_pc($sformatf("ib_pc_o[%0d]", i), ib_pc[i], on ? pc + 32'(4 * i) : '0);
            check_instr($sformatf("ib_instr_o[%0d]", i), ib_instr[i],
                        on ? golden[base + 5 + i] : '0);
        end
    endtask

    task automatic wait_accept(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++) begin
            @(negedge clk);
            ok = ftq_accept;
        end
        if (!ok) begin
            err_count++;
            $display("Timeout: block at %h was never accepted", ftq_start_pc);
        end
    endtask

    // Follows every beat, returns in the cycle of the final ack
    task automatic run_bus(input logic [31:0] pc, input int len, output bit ok);
        logic [31:0] line;
        int          beats;
        int          k;
        line = {pc[31:4], 4'h0};
        beats = (int'(pc[3:2]) + len > fetch_pkg::LINE_WORDS) ? 8 : 4;
        k = 0;
        for (int n = 0; n < TIMEOUT && k < beats; n++) begin
            check_flag("any ib_valid_o", |ib_valid, 1'b0);
            // Request held through every cycle of the bus phase
            check_flag("wb_cyc_o", wb_cyc, 1'b1);
            check_flag("wb_stb_o", wb_stb, 1'b1);
            if (wb_ack) begin
                check_pc("wb_adr_o", wb_adr, line + 32'(4 * k));
                k++;
            end
            if (k < beats) begin
                @(negedge clk);
            end
        end
        ok = (k == beats);
        if (!ok) begin
            err_count++;
            $display("Timeout: only %0d of %0d beats acknowledged", k, beats);
        end
    endtask

    task automatic deliver(input logic [31:0] pc, input int len, input int base,
                           input int stall_n, input bit settle);
        @(posedge clk);
        if (stall_n > 0) begin
            ib_stall <= 1'b1;
            // Queue offers another block while the buffer is full
            ftq_valid <= 1'b1;
        end
        @(negedge clk);
        check_slots(pc, len, base);
        for (int n = 1; n <= stall_n; n++) begin
            @(posedge clk);
            if (n == stall_n) begin
                ib_stall <= 1'b0;
                ftq_valid <= 1'b0;
            end
            @(negedge clk);
            check_slots(pc, len, base);
            check_flag("ftq_accept_o", ftq_accept, 1'b0);
        end
        if (settle) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("any ib_valid_o", |ib_valid, 1'b0);
        end
    endtask

    task automatic flush_block(input int delay);
        repeat (delay - 1) @(negedge clk);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_flag("wb_cyc_o", wb_cyc, 1'b1);
        @(posedge clk);
        flush <= 1'b0;
        // Bus abandoned and nothing delivered afterwards
        repeat (10) begin
            @(negedge clk);
            check_flag("wb_cyc_o", wb_cyc, 1'b0);
            check_flag("wb_stb_o", wb_stb, 1'b0);
            check_flag("any ib_valid_o", |ib_valid, 1'b0);
        end
    endtask

    task automatic run_test(input int t);
        int          base;
        int          kind;
        logic [31:0] pc;
        int          len;
        int          stall_n;
        int          flush_d;
        int          errs_before;
        bit          ok;
        base = t * FIELDS;
        kind = int'(golden[base]);
        pc = golden[base + 1];
        len = int'(golden[base + 2]);
        stall_n = int'(golden[base + 3]);
        flush_d = int'(golden[base + 4]);
        errs_before = err_count;
        @(posedge clk);
        ftq_valid <= 1'b1;
        ftq_start_pc <= pc;
        ftq_length <= fetch_pkg::LEN_W'(len);
        wait_accept(ok);
        if (ok) begin
            @(posedge clk);
            ftq_valid <= 1'b0;
            @(negedge clk);
            check_flag("wb_stb_o", wb_stb, 1'b1);
            if (flush_d > 0) begin
                flush_block(flush_d);
            end else begin
                run_bus(pc, len, ok);
                if (ok) begin
                    deliver(pc, len, base, stall_n, kind != KIND_B2B);
                end
            end
        end
        if (!ok) begin
            timed_out = 1'b1;
        end
        $display("test %0d kind %0d pc %h len %0d: %s", t, kind, pc, len,
                 (err_count == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int t;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        timed_out = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        ftq_valid = 1'b0;
        ftq_start_pc = '0;
        ftq_length = '0;
        ib_stall = 1'b0;
        for (t = 0; t < MAX_TESTS * FIELDS; t++) begin
            golden[t] = '0;
        end
        $readmemh("bench/fetch_golden.txt", golden);
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_flag("ftq_accept_o", ftq_accept, 1'b0);
        check_flag("wb_cyc_o", wb_cyc, 1'b0);
        check_flag("wb_stb_o", wb_stb, 1'b0);
        check_flag("any ib_valid_o", |ib_valid, 1'b0);
        @(posedge clk);
        rst_n <= 1'b1;
        t = 0;
        while (t < MAX_TESTS && golden[t * FIELDS] != 0 && !timed_out) begin
            run_test(t);
            t++;
            test_count++;
        end
        if (test_count == 0) begin
            err_count++;
            $display("No tests found in the golden file");
        end
        err_count += fetch_unit_i.fetch_unit_properties_i.fail_count;
        $display("tests %0d checks %0d errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- bench/fetch_golden.txt
// kind start_pc length stall_cycles flush_delay instr0 instr1 instr2 instr3
// kind 1 aligned, 2 short, 3 line cross, 4 stall, 5 flush, 6 back-to-back
1 00001000 4 0 0 13571000 13571004 13571008 1357100C
2 00002004 3 0 0 13572004 13572008 1357200C 00000000
2 0000300C 1 0 0 1357300C 00000000 00000000 00000000
2 00003408 2 0 0 13573408 1357340C 00000000 00000000
3 0000400C 4 0 0 1357400C 13574010 13574014 13574018
3 00005008 3 0 0 13575008 1357500C 13575010 00000000
4 00006000 4 5 0 13576000 13576004 13576008 1357600C
4 00006104 4 3 0 13576104 13576108 1357610C 13576110
5 00007004 4 0 2 00000000 00000000 00000000 00000000
1 00007000 4 0 0 13577000 13577004 13577008 1357700C
5 0000700C 2 0 1 00000000 00000000 00000000 00000000
3 0000700C 2 0 0 1357700C 13577010 00000000 00000000
6 00008008 4 0 0 13578008 1357800C 13578010 13578014
6 00008010 2 0 0 13578010 13578014 00000000 00000000
6 0000801C 3 0 0 1357801C 13578020 13578024 00000000
6 00008024 1 0 0 13578024 00000000 00000000 00000000
6 0000FFF8 4 0 0 1357FFF8 1357FFFC 13560000 13560004

//--- tb.f
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/fetch_beat_counter.sv
design/fetch_line_buffer.sv
design/fetch_slicer.sv
design/fetch_unit.sv
bench/wb_inst_mem.sv
bench/fetch_unit_properties.sv
bench/fetch_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)
